// File: hw/noise_pkg.sv
`default_nettype none

package noise_pkg;

    // signed input sample
    // the ternary noise value uses the same type
    typedef logic signed [7:0] sample_t;

    // mixer result, wide enough for sample * gain + noise
    typedef logic signed [15:0] mixed_t;

    // one uniform random word
    typedef logic [63:0] rand_word_t;

    // generator state after reset, must be nonzero
    localparam rand_word_t URNG_SEED = 64'h9E37_79B9_7F4A_7C15;

    // xorshift64 triple
    // applied as left, right, left
    localparam int XS_A = 13;
    localparam int XS_B = 7;
    localparam int XS_C = 17;

    // words below this map to 0
    localparam rand_word_t THRESH_ZERO = 64'h7FFF_FFFF_FFFF_FFFF;
    // words below this (and not below THRESH_ZERO) map to +1
    // everything above, all-ones included, maps to -1
    localparam rand_word_t THRESH_POS = 64'hBFFF_FFFF_FFFF_FFFF;

    // the three noise levels
    localparam sample_t NOISE_ZERO = 8'sd0;
    localparam sample_t NOISE_POS = 8'sd1;
    localparam sample_t NOISE_NEG = -8'sd1;

    // fixed gain on the input sample
    localparam int NOISE_GAIN = 28;

    // noise queue size
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

    // queue index and occupancy
    // count needs one extra bit to reach FIFO_DEPTH
    typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;
    typedef logic [FIFO_PTR_W:0] fifo_cnt_t;

endpackage

`default_nettype wire

// File: hw/urng_xorshift64.sv
`timescale 1ns/10ps
`default_nettype none

module urng_xorshift64 (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   advance,
    output noise_pkg::rand_word_t  rand_word
);

    // generator state
    noise_pkg::rand_word_t state;

    // one xorshift step, split in three stages
    noise_pkg::rand_word_t step_a;
    noise_pkg::rand_word_t step_b;
    noise_pkg::rand_word_t step_c;

    always_comb begin
        // left shift first
        step_a = state ^ (state << noise_pkg::XS_A);
        // then right
        step_b = step_a ^ (step_a >> noise_pkg::XS_B);
        // then left again
        step_c = step_b ^ (step_b << noise_pkg::XS_C);
    end

    // state only moves when the mapper takes the word
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= noise_pkg::URNG_SEED;
        end else if (advance) begin
            state <= step_c;
        end
    end

    // word is always valid
    // no separate valid flag needed
    assign rand_word = state;

endmodule

`default_nettype wire

// File: hw/ternary_noise_map.sv
`timescale 1ns/10ps
`default_nettype none

module ternary_noise_map (
    input  logic               clk,
    input  logic               rstn,
    input  logic               en,
    output logic               noise_valid,
    input  logic               noise_ready,
    output noise_pkg::sample_t noise_value
);

    // current uniform word
    noise_pkg::rand_word_t rand_word;
    // level for the current word
    noise_pkg::sample_t    mapped;
    // load the output slot this cycle
    logic                  fill;

    urng_xorshift64 u_urng (
        .clk       (clk),
        .rstn      (rstn),
        .advance   (fill),
        .rand_word (rand_word)
    );

    // threshold compare
    // top band also takes the all-ones word
    always_comb begin
        if (rand_word < noise_pkg::THRESH_ZERO) begin
            mapped = noise_pkg::NOISE_ZERO;
        end else if (rand_word < noise_pkg::THRESH_POS) begin
            mapped = noise_pkg::NOISE_POS;
        end else begin
            mapped = noise_pkg::NOISE_NEG;
        end
    end

    // slot empty or being taken, and draws enabled
    // fill also advances the generator so one word per sample
    assign fill = en && (!noise_valid || noise_ready);

    // slot occupancy
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            noise_valid <= 1'b0;
        end else if (fill) begin
            noise_valid <= 1'b1;
        end else if (noise_ready) begin
            // taken with en low
            noise_valid <= 1'b0;
        end
    end

    // slot payload
    always_ff @(posedge clk) begin
        if (fill) begin
            noise_value <= mapped;
        end
    end

endmodule

`default_nettype wire

// File: hw/noise_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module noise_fifo (
    input  logic               clk,
    input  logic               rstn,
    input  logic               wr_valid,
    output logic               wr_ready,
    input  noise_pkg::sample_t wr_data,
    output logic               rd_valid,
    input  logic               rd_ready,
    output noise_pkg::sample_t rd_data
);

    // storage
    noise_pkg::sample_t mem [noise_pkg::FIFO_DEPTH];

    // pointers and occupancy
    noise_pkg::fifo_ptr_t wr_ptr;
    noise_pkg::fifo_ptr_t rd_ptr;
    noise_pkg::fifo_cnt_t count;

    logic full;
    logic empty;
    logic do_wr;
    logic do_rd;

    // status from count only
    assign full = (count == noise_pkg::fifo_cnt_t'(noise_pkg::FIFO_DEPTH));
    assign empty = (count == '0);

    assign wr_ready = !full;
    assign rd_valid = !empty;

    // accepted transfers
    assign do_wr = wr_valid && wr_ready;
    assign do_rd = rd_valid && rd_ready;

    // head entry straight out of the array
    assign rd_data = mem[rd_ptr];

    // write side
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
        end else if (do_wr) begin
            // wrap at the last entry
            if (wr_ptr == noise_pkg::fifo_ptr_t'(noise_pkg::FIFO_DEPTH - 1)) begin
                wr_ptr <= '0;
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    // read side
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rd_ptr <= '0;
        end else if (do_rd) begin
            if (rd_ptr == noise_pkg::fifo_ptr_t'(noise_pkg::FIFO_DEPTH - 1)) begin
                rd_ptr <= '0;
            end else begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // occupancy
    // simultaneous read and write leaves it unchanged
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            count <= '0;
        end else if (do_wr && !do_rd) begin
            count <= count + 1'b1;
        end else if (do_rd && !do_wr) begin
            count <= count - 1'b1;
        end
    end

    // entry write
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

endmodule

`default_nettype wire

// File: hw/noise_mixer.sv
`timescale 1ns/10ps
`default_nettype none

module noise_mixer (
    input  logic               clk,
    input  logic               rstn,
    input  logic               in_valid,
    output logic               in_ready,
    input  noise_pkg::sample_t in_sample,
    input  logic               nq_valid,
    output logic               nq_ready,
    input  noise_pkg::sample_t nq_value,
    output logic               out_valid,
    input  logic               out_ready,
    output noise_pkg::mixed_t  out_data
);

    // join this cycle
    logic join_go;

    // widened operands
    noise_pkg::mixed_t sample_ext;
    noise_pkg::mixed_t noise_ext;
    noise_pkg::mixed_t scaled;
    noise_pkg::mixed_t sum;

    // both streams present and output slot free or draining
    assign join_go = in_valid && nq_valid && (!out_valid || out_ready);

    // both sides taken together
    // keeps sample n paired with noise n
    assign in_ready = join_go;
    assign nq_ready = join_go;

    // sign extension to 16 bits
    assign sample_ext = noise_pkg::mixed_t'(in_sample);
    assign noise_ext = noise_pkg::mixed_t'(nq_value);

    // full-width product, range fits in 16 bits
    assign scaled = sample_ext * noise_pkg::mixed_t'(noise_pkg::NOISE_GAIN);
    assign sum = scaled + noise_ext;

    // output slot flag
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            out_valid <= 1'b0;
        end else if (join_go) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // result register
    // holds while out_ready is low
    always_ff @(posedge clk) begin
        if (join_go) begin
            out_data <= sum;
        end
    end

endmodule

`default_nettype wire

// File: hw/noise_injector_top.sv
`timescale 1ns/10ps
`default_nettype none

module noise_injector_top (
    input  logic               clk,
    input  logic               rstn,
    input  logic               en,
    input  logic               in_valid,
    output logic               in_ready,
    input  noise_pkg::sample_t in_sample,
    output logic               out_valid,
    input  logic               out_ready,
    output noise_pkg::mixed_t  out_data
);

    // mapper to fifo
    logic               noise_valid;
    logic               noise_ready;
    noise_pkg::sample_t noise_value;

    // fifo to mixer
    logic               nq_valid;
    logic               nq_ready;
    noise_pkg::sample_t nq_value;

    // producer
    // generator sits inside the mapper
    ternary_noise_map u_map (
        .clk         (clk),
        .rstn        (rstn),
        .en          (en),
        .noise_valid (noise_valid),
        .noise_ready (noise_ready),
        .noise_value (noise_value)
    );

    // noise queue
    noise_fifo u_fifo (
        .clk      (clk),
        .rstn     (rstn),
        .wr_valid (noise_valid),
        .wr_ready (noise_ready),
        .wr_data  (noise_value),
        .rd_valid (nq_valid),
        .rd_ready (nq_ready),
        .rd_data  (nq_value)
    );

    // consumer
    noise_mixer u_mixer (
        .clk       (clk),
        .rstn      (rstn),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_sample (in_sample),
        .nq_valid  (nq_valid),
        .nq_ready  (nq_ready),
        .nq_value  (nq_value),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

endmodule

`default_nettype wire

// File: verif/noise_injector_checker.sv
`timescale 1ns/10ps
`default_nettype none

module noise_injector_checker (
    input logic              clk,
    input logic              rstn,
    input logic              in_ready,
    input logic              noise_valid,
    input logic              out_valid,
    input logic              out_ready,
    input noise_pkg::mixed_t out_data
);

    // result stays offered until accepted
    property p_valid_hold;
        @(posedge clk) disable iff (!rstn)
        out_valid && !out_ready |=> out_valid;
    endproperty

    // payload frozen while stalled
    property p_data_stable;
        @(posedge clk) disable iff (!rstn)
        out_valid && !out_ready |=> $stable(out_data);
    endproperty

    // nothing offered while in reset
    property p_reset_quiet;
        @(posedge clk)
        !rstn |-> (!out_valid && !in_ready && !noise_valid);
    endproperty

    a_valid_hold: assert property (p_valid_hold)
        else $error("out_valid dropped before out_ready accepted it");

    a_data_stable: assert property (p_data_stable)
        else $error("out_data changed while out_valid was stalled");

    a_reset_quiet: assert property (p_reset_quiet)
        else $error("handshake signal high during reset");

endmodule

`default_nettype wire

// File: verif/tb_noise_injector.sv
`timescale 1ns/10ps
`default_nettype none

module tb_noise_injector;

    localparam int DRIVE_DELAY = 10;
    localparam int TIMEOUT = 200;
    // idle cycles with draws off before a stall counts as gated
    localparam int GATE_CYCLES = 12;

    // one table row
    typedef struct packed {
        noise_pkg::sample_t sample;
        logic               en;
        int                 gap;
        int                 hold;
        logic               burst;
        noise_pkg::mixed_t  exp;
    } entry_t;

    logic               clk;
    logic               rstn;
    logic               en;
    logic               in_valid;
    logic               in_ready;
    noise_pkg::sample_t in_sample;
    logic               out_valid;
    logic               out_ready;
    noise_pkg::mixed_t  out_data;

    entry_t      tbl[$];
    logic [31:0] rng;
    int          gate_stalls;
    // noise levels seen by the model
    logic        seen_zero;
    logic        seen_pos;
    logic        seen_neg;

    noise_injector_top dut (
        .clk       (clk),
        .rstn      (rstn),
        .en        (en),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_sample (in_sample),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    bind noise_injector_top noise_injector_checker u_checker (
        .clk         (clk),
        .rstn        (rstn),
        .in_ready    (in_ready),
        .noise_valid (noise_valid),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_data    (out_data)
    );

    always #50 clk = ~clk;

    task automatic stop_with_fail();
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_mixed(input noise_pkg::mixed_t got, input noise_pkg::mixed_t exp,
                               input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, what, got, exp);
            stop_with_fail();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
            stop_with_fail();
        end
    endtask

    // 32-bit xorshift for extra stimulus
    function automatic noise_pkg::sample_t rand_sample();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return noise_pkg::sample_t'(rng[15:8]);
    endfunction

    // reference generator step, left right left
    function automatic noise_pkg::rand_word_t model_step(input noise_pkg::rand_word_t s);
        noise_pkg::rand_word_t x;
        x = s ^ (s << noise_pkg::XS_A);
        x = x ^ (x >> noise_pkg::XS_B);
        x = x ^ (x << noise_pkg::XS_C);
        return x;
    endfunction

    // ternary bands, all-ones word lands in the top band
    function automatic int model_level(input noise_pkg::rand_word_t w);
        if (w < noise_pkg::THRESH_ZERO) begin
            return 0;
        end else if (w < noise_pkg::THRESH_POS) begin
            return 1;
        end
        return -1;
    endfunction

    task automatic add_entry(input noise_pkg::sample_t s, input logic e, input int gap,
                             input int hold, input logic burst);
        entry_t ent;
        ent.sample = s;
        ent.en = e;
        ent.gap = gap;
        ent.hold = hold;
        ent.burst = burst;
        ent.exp = '0;
        tbl.push_back(ent);
    endtask

    task automatic build_table();
        // ordered mixing, extremes first
        add_entry(-8'sd128, 1'b1, 0, 0, 1'b0);
        add_entry(8'sd127, 1'b1, 0, 0, 1'b0);
        add_entry(8'sd0, 1'b1, 0, 0, 1'b0);
        add_entry(8'sd1, 1'b1, 0, 0, 1'b0);
        add_entry(-8'sd1, 1'b1, 0, 0, 1'b0);
        add_entry(8'sd64, 1'b1, 0, 0, 1'b0);
        repeat (4) add_entry(rand_sample(), 1'b1, 0, 0, 1'b0);
        // output back-pressure
        add_entry(8'sd5, 1'b1, 0, 4, 1'b0);
        add_entry(rand_sample(), 1'b1, 0, 0, 1'b0);
        add_entry(rand_sample(), 1'b1, 0, 6, 1'b0);
        add_entry(-8'sd100, 1'b1, 0, 0, 1'b0);
        add_entry(rand_sample(), 1'b1, 0, 0, 1'b0);
        // idle gap fills the queue, then one per cycle
        add_entry(8'sd100, 1'b1, 8, 0, 1'b1);
        repeat (5) add_entry(rand_sample(), 1'b1, 0, 0, 1'b1);
        // draws off, queue runs dry within these
        add_entry(8'sd3, 1'b0, 0, 0, 1'b0);
        repeat (5) add_entry(rand_sample(), 1'b0, 0, 0, 1'b0);
        add_entry(-8'sd7, 1'b0, 0, 0, 1'b0);
        // back to normal
        add_entry(8'sd127, 1'b1, 0, 0, 1'b0);
        add_entry(-8'sd128, 1'b1, 0, 0, 1'b0);
        add_entry(rand_sample(), 1'b1, 0, 0, 1'b0);
    endtask

    // n-th input pairs with the n-th generator word
    task automatic compute_expected();
        noise_pkg::rand_word_t state;
        int level;
        state = noise_pkg::URNG_SEED;
        for (int i = 0; i < tbl.size(); i++) begin
            level = model_level(state);
            state = model_step(state);
            seen_zero |= (level == 0);
            seen_pos |= (level == 1);
            seen_neg |= (level == -1);
            tbl[i].exp = noise_pkg::mixed_t'(int'(tbl[i].sample) * noise_pkg::NOISE_GAIN + level);
        end
    endtask

    task automatic offer_sample(input int idx);
        int n;
        repeat (tbl[idx].gap) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
        en = tbl[idx].en;
        in_sample = tbl[idx].sample;
        in_valid = 1'b1;
        n = 0;
        @(negedge clk);
        if (tbl[idx].burst) begin
            check_flag(in_ready, 1'b1, "in_ready during burst");
        end
        while (!in_ready) begin
            n++;
            if (!en && n >= GATE_CYCLES) begin
                // queue must be empty here
                check_flag(dut.nq_valid, 1'b0, "noise queue drained with draws off");
                gate_stalls++;
                @(posedge clk);
                #DRIVE_DELAY;
                en = 1'b1;
            end
            if (n > TIMEOUT) begin
                $display("timeout: input entry %0d was never accepted", idx);
                stop_with_fail();
            end
            @(negedge clk);
        end
        @(posedge clk);
        #DRIVE_DELAY;
        in_valid = 1'b0;
    endtask

    task automatic wait_out_valid(input int idx);
        int n;
        n = 0;
        @(negedge clk);
        while (!out_valid) begin
            n++;
            if (n > TIMEOUT) begin
                $display("timeout: no result appeared for entry %0d", idx);
                stop_with_fail();
            end
            @(negedge clk);
        end
    endtask

    task automatic collect_result(input int idx);
        noise_pkg::mixed_t held;
        wait_out_valid(idx);
        check_mixed(out_data, tbl[idx].exp, $sformatf("out_data of entry %0d", idx));
        held = out_data;
        if (tbl[idx].hold > 0) begin
            // stalled result must hold, input side blocked
            for (int k = 0; k < tbl[idx].hold; k++) begin
                @(posedge clk);
                #DRIVE_DELAY;
                @(negedge clk);
                check_flag(out_valid, 1'b1, "out_valid under back-pressure");
                check_mixed(out_data, held, "out_data under back-pressure");
                check_flag(in_ready, 1'b0, "in_ready under back-pressure");
            end
            @(posedge clk);
            #DRIVE_DELAY;
            out_ready = 1'b1;
            @(negedge clk);
            check_flag(out_valid, 1'b1, "out_valid at release");
        end
        @(posedge clk);
        #DRIVE_DELAY;
        // prepare stall for the next result
        if (idx + 1 < tbl.size()) begin
            out_ready = (tbl[idx + 1].hold == 0);
        end else begin
            out_ready = 1'b1;
        end
    endtask

    initial begin
        clk = 1'b0;
        rstn = 1'b0;
        en = 1'b0;
        in_valid = 1'b0;
        in_sample = '0;
        out_ready = 1'b0;
        rng = 32'd68;
        gate_stalls = 0;
        seen_zero = 1'b0;
        seen_pos = 1'b0;
        seen_neg = 1'b0;
        build_table();
        compute_expected();
        // four rising edges in reset
        repeat (3) begin
            @(negedge clk);
            check_flag(out_valid, 1'b0, "out_valid in reset");
            check_flag(in_ready, 1'b0, "in_ready in reset");
        end
        @(posedge clk);
        #DRIVE_DELAY;
        rstn = 1'b1;
        en = 1'b1;
        out_ready = (tbl[0].hold == 0);
        @(negedge clk);
        check_flag(out_valid, 1'b0, "out_valid after reset");
        check_flag(in_ready, 1'b0, "in_ready after reset");
        @(posedge clk);
        #DRIVE_DELAY;
        fork
            for (int i = 0; i < tbl.size(); i++) begin
                offer_sample(i);
            end
            for (int j = 0; j < tbl.size(); j++) begin
                collect_result(j);
            end
        join
        check_flag(gate_stalls > 0, 1'b1, "input blocked with draws off");
        check_flag(seen_zero && seen_pos && seen_neg, 1'b1, "all three noise levels used");
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
hw/noise_pkg.sv
hw/urng_xorshift64.sv
hw/ternary_noise_map.sv
hw/noise_fifo.sv
hw/noise_mixer.sv
hw/noise_injector_top.sv
verif/noise_injector_checker.sv
verif/tb_noise_injector.sv
